//--- button_latch.sv
// Lamp register and single request acceptance for one bank of floor buttons
`timescale 1ns/1ps
`default_nettype none

module button_latch (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire floor_pkg::floor_mask_t buttons,
    input  wire floor_pkg::floor_t      current_floor,
    input  wire                   clear_all,
    input  wire                   serve,
    output floor_pkg::floor_mask_t lights,
    output logic                  req_valid,
    output floor_pkg::floor_t      req_floor
);

    import floor_pkg::*;

    floor_mask_t accept;
    floor_mask_t cur_mask;
    floor_mask_t req_mask;

    ////////////////////
    // Acceptance
    ////////////////////

    // Pressed, lamp still dark, not the floor we are standing at
    always_comb begin
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            accept[i] = buttons[i] && !lights[i] && !clear_all &&
                        (floor_t'(i) != current_floor);
        end
    end

    // Scan from the top so the lowest index is the one left standing
    always_comb begin
        req_valid = 1'b0;
        req_floor = '0;
        for (int i = FLOOR_COUNT - 1; i >= 0; i--) begin
            if (accept[i]) begin
                req_valid = 1'b1;
                req_floor = floor_t'(i);
            end
        end
    end

    ////////////////////
    // Lamps
    ////////////////////

    assign cur_mask = floor_mask_t'(1) << current_floor;
    assign req_mask = req_valid ? (floor_mask_t'(1) << req_floor) : '0;

    // Served floor goes dark, new request lights up
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (clear_all) begin
            lights <= '0;
        end else begin
            lights <= (serve ? (lights & ~cur_mask) : lights) | req_mask;
        end
    end

    // An accepted request names a dark lamp, which is lit one edge later
    a_req_lights: assert property (@(posedge clock) disable iff (!reset_n)
        req_valid |-> !lights[req_floor] ##1 lights[$past(req_floor)]);

endmodule

`default_nettype wire

//--- floor_dispatcher.sv
// Target and direction choice, start decision, service, clearing and door gating
`timescale 1ns/1ps
`default_nettype none

module floor_dispatcher (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    input  wire floor_pkg::floor_t     current_floor_state,
    input  wire floor_pkg::fsm_state_t elevator_state,
    input  wire                       cab_req_valid,
    input  wire floor_pkg::floor_t     cab_req_floor,
    input  wire                       hall_req_valid,
    input  wire floor_pkg::floor_t     hall_req_floor,
    output logic                      clear_all,
    output logic                      serve,
    output floor_pkg::floor_t          elevator_floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import floor_pkg::*;

    logic   is_stop;
    logic   emergency_active;
    logic   stack_empty;
    floor_t top_floor;
    floor_t target;
    logic   going_up;
    logic   dir_q;

    assign is_stop          = (elevator_state <= STOP_LAST);
    assign emergency_active = power_switch && emergency_btn;

    ////////////////////
    // Clearing and service
    ////////////////////

    assign clear_all = !power_switch || emergency_btn;
    // Standing still with nothing else to go to, so the current floor is done
    assign serve     = is_stop && !clear_all && !activate_elevator;

    floor_request_stack u_stack (
        .clock        (clock),
        .reset_n      (reset_n),
        .clear        (clear_all),
        .remove       (serve),
        .remove_floor (current_floor_state),
        .cab_valid    (cab_req_valid),
        .cab_floor    (cab_req_floor),
        .hall_valid   (hall_req_valid),
        .hall_floor   (hall_req_floor),
        .top_floor    (top_floor),
        .empty        (stack_empty)
    );

    ////////////////////
    // Target, start, direction
    ////////////////////

    assign target   = stack_empty ? current_floor_state : top_floor;
    assign going_up = (target > current_floor_state);

    assign activate_elevator = !clear_all && is_stop && !stack_empty &&
                               (top_floor != current_floor_state);

    assign elevator_floor_selector = emergency_active ? EMERGENCY_FLOOR : target;

    // Direction is only decided at a start, kept otherwise
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dir_q <= 1'b1;
        end else if (emergency_active) begin
            dir_q <= 1'b1;
        end else if (activate_elevator) begin
            dir_q <= going_up;
        end
    end

    assign direction_selector = emergency_active  ? 1'b1 :
                                activate_elevator ? going_up : dir_q;

    // Doors only respond at a stop with power on
    assign door_open_allowed  = power_switch && is_stop && door_open_btn;
    assign door_close_allowed = power_switch && is_stop && door_close_btn;

    a_no_self_start: assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (elevator_floor_selector != current_floor_state));

endmodule

`default_nettype wire

//--- floor_logic.f
floor_pkg.sv
button_latch.sv
floor_request_stack.sv
floor_dispatcher.sv
floor_logic_control_unit.sv
tb_floor_logic.sv

//--- floor_logic_control_unit.sv
// Top level of the floor request controller, two button latches and the dispatcher
`timescale 1ns/1ps
`default_nettype none

module floor_logic_control_unit (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire floor_pkg::floor_mask_t floor_call_buttons,
    input  wire floor_pkg::floor_mask_t panel_buttons,
    input  wire                        door_open_btn,
    input  wire                        door_close_btn,
    input  wire                        emergency_btn,
    input  wire                        power_switch,
    input  wire floor_pkg::floor_t      current_floor_state,
    input  wire floor_pkg::fsm_state_t  elevator_state,
    output floor_pkg::floor_t           elevator_floor_selector,
    output logic                       direction_selector,
    output logic                       activate_elevator,
    output floor_pkg::floor_mask_t      call_button_lights,
    output floor_pkg::floor_mask_t      panel_button_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import floor_pkg::*;

    logic   clear_all;
    logic   serve;
    logic   hall_req_valid;
    floor_t hall_req_floor;
    logic   cab_req_valid;
    floor_t cab_req_floor;

    ////////////////////
    // Button banks
    ////////////////////

    // Hall calls
    button_latch hall_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (floor_call_buttons),
        .current_floor (current_floor_state),
        .clear_all     (clear_all),
        .serve         (serve),
        .lights        (call_button_lights),
        .req_valid     (hall_req_valid),
        .req_floor     (hall_req_floor)
    );

    // Cab panel
    button_latch cab_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (panel_buttons),
        .current_floor (current_floor_state),
        .clear_all     (clear_all),
        .serve         (serve),
        .lights        (panel_button_lights),
        .req_valid     (cab_req_valid),
        .req_floor     (cab_req_floor)
    );

    ////////////////////
    // Dispatch
    ////////////////////

    floor_dispatcher u_dispatcher (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .cab_req_valid           (cab_req_valid),
        .cab_req_floor           (cab_req_floor),
        .hall_req_valid          (hall_req_valid),
        .hall_req_floor          (hall_req_floor),
        .clear_all               (clear_all),
        .serve                   (serve),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

//--- floor_pkg.sv
// Shared floor count, state codes and the floor, mask and FSM state types
`default_nettype none

package floor_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Floors served, numbered 0 to 10
    localparam int FLOOR_COUNT = 11;

    // Width of a floor number
    localparam int FLOOR_BITS = 4;

    // Width of the elevator FSM state code
    localparam int STATE_BITS = 6;

    ////////////////////
    // Types
    ////////////////////

    // Floor number
    typedef logic [FLOOR_BITS-1:0] floor_t;

    // One bit per floor, for buttons and lamps
    typedef logic [FLOOR_COUNT-1:0] floor_mask_t;

    // State code from the elevator FSM
    typedef logic [STATE_BITS-1:0] fsm_state_t;

    ////////////////////
    // Codes
    ////////////////////

    // Codes 0 to 10 are the stop states, one per floor
    localparam fsm_state_t STOP_LAST = 6'h0A;

    // Selector value while an emergency is active
    localparam floor_t EMERGENCY_FLOOR = 4'hF;

endpackage

`default_nettype wire

//--- floor_request_stack.sv
// Duplicate-free request store, newest floor on top, compacted on removal
`timescale 1ns/1ps
`default_nettype none

module floor_request_stack (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   clear,
    input  wire                   remove,
    input  wire floor_pkg::floor_t remove_floor,
    input  wire                   cab_valid,
    input  wire floor_pkg::floor_t cab_floor,
    input  wire                   hall_valid,
    input  wire floor_pkg::floor_t hall_floor,
    output floor_pkg::floor_t      top_floor,
    output logic                  empty
);

    import floor_pkg::*;

    // Entry 0 is the oldest, entry count_q-1 the top
    floor_t                stack_q [FLOOR_COUNT];
    floor_t                stack_d [FLOOR_COUNT];
    logic [FLOOR_BITS-1:0] count_q;
    logic [FLOOR_BITS-1:0] count_d;
    logic [FLOOR_BITS-1:0] top_idx;

    // True when floor f sits in the lowest n entries of arr
    function automatic logic in_stack(input floor_t arr [FLOOR_COUNT], input int n,
                                      input floor_t f);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            if (i < n && arr[i] == f) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    ////////////////////
    // Next contents
    ////////////////////

    always_comb begin
        int k;
        stack_d = stack_q;
        k = 0;
        // Drop the served floor and close the gap
        for (int i = 0; i < FLOOR_COUNT; i++) begin
            if (i < int'(count_q) && !(remove && stack_q[i] == remove_floor)) begin
                stack_d[k] = stack_q[i];
                k = k + 1;
            end
        end
        // Cab request first, hall request ends up above it
        if (cab_valid && !in_stack(stack_d, k, cab_floor)) begin
            stack_d[k] = cab_floor;
            k = k + 1;
        end
        if (hall_valid && !in_stack(stack_d, k, hall_floor)) begin
            stack_d[k] = hall_floor;
            k = k + 1;
        end
        count_d = k[FLOOR_BITS-1:0];
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clock) begin
        stack_q <= stack_d;
    end

    assign empty     = (count_q == '0);
    assign top_idx   = count_q - 1'b1;
    assign top_floor = empty ? '0 : stack_q[top_idx];

    a_count_max: assert property (@(posedge clock) disable iff (!reset_n)
        count_q <= FLOOR_COUNT);

    // Every pair of live entries holds different floors
    for (genvar i = 0; i < FLOOR_COUNT; i++) begin : g_uniq_i
        for (genvar j = i + 1; j < FLOOR_COUNT; j++) begin : g_uniq_j
            a_unique: assert property (@(posedge clock) disable iff (!reset_n)
                (j < count_q) |-> (stack_q[i] != stack_q[j]));
        end
    end

endmodule

`default_nettype wire

//--- run_floor_logic.sh
#!/bin/sh
# Build and run the floor logic testbench with Verilator
set -e

LOG=run_floor_logic.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_floor_logic \
    -f floor_logic.f -o sim_floor_logic

./obj_dir/sim_floor_logic 2>&1 | tee "$LOG"

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    exit 1
fi
grep -qF '*** TEST PASSED ***' "$LOG"

//--- tb_floor_logic.sv
// Directed testbench for the floor request controller with clock, reset, tests and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_floor_logic;

    import floor_pkg::*;

    localparam int         CYCLE_LIMIT  = 400;
    localparam fsm_state_t MOVING_STATE = 6'h2C;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    fsm_state_t  elevator_state;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;

    floor_logic_control_unit uut (.*);

    always #5 clock = ~clock;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // Returns at the falling edge, where registered outputs are settled
    task automatic next_edge();
        @(posedge clock);
        @(negedge clock);
    endtask

    function automatic floor_mask_t floor_bit(input floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

    function automatic floor_t other_floor(input floor_t avoid);
        return floor_t'((int'(avoid) + 1 + $urandom % (FLOOR_COUNT - 1)) % FLOOR_COUNT);
    endfunction

    task automatic stop_at(input floor_t f);
        current_floor_state = f;
        elevator_state      = fsm_state_t'(f);
    endtask

    // One-cycle press on the cab or hall bank
    task automatic press(input logic cab, input floor_t f);
        if (cab) begin
            panel_buttons = floor_bit(f);
        end else begin
            floor_call_buttons = floor_bit(f);
        end
        next_edge();
        panel_buttons      = '0;
        floor_call_buttons = '0;
    endtask

    // Short power dip empties lamps and stack
    task automatic drop_requests();
        next_edge();
        power_switch = 1'b0;
        next_edge();
        power_switch = 1'b1;
    endtask

    task automatic end_run();
        $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic after_reset();
        expect_equal("call_button_lights", call_button_lights, '0);
        expect_equal("panel_button_lights", panel_button_lights, '0);
        expect_equal("activate_elevator", activate_elevator, 0);
        expect_equal("door_open_allowed", door_open_allowed, 0);
        expect_equal("door_close_allowed", door_close_allowed, 0);
        expect_equal("direction_selector", direction_selector, 1);
        expect_equal("elevator_floor_selector", elevator_floor_selector, current_floor_state);
    endtask

    task automatic accept_requests();
        floor_t f;
        floor_t g;
        f = floor_t'($urandom % FLOOR_COUNT);
        g = other_floor(f);
        drop_requests();
        stop_at(f);
        press(1'b1, g);
        expect_equal("panel_button_lights", panel_button_lights, floor_bit(g));
        expect_equal("elevator_floor_selector", elevator_floor_selector, g);
        expect_equal("activate_elevator", activate_elevator, 1);
        expect_equal("direction_selector", direction_selector, g > f);
        // A press for the floor we stand at lights nothing
        press(1'b1, f);
        expect_equal("panel_button_lights", panel_button_lights, floor_bit(g));
        expect_equal("elevator_floor_selector", elevator_floor_selector, g);
    endtask

    task automatic most_recent_first();
        floor_t f;
        floor_t a;
        floor_t b;
        f = floor_t'($urandom % FLOOR_COUNT);
        a = other_floor(f);
        b = floor_t'((a + 1) % FLOOR_COUNT);
        if (b == f) begin
            b = floor_t'((b + 1) % FLOOR_COUNT);
        end
        drop_requests();
        stop_at(f);
        press(1'b0, a);
        press(1'b1, b);
        // Same floor from the hall lights its lamp but adds no second entry
        press(1'b0, b);
        expect_equal("call_button_lights", call_button_lights, floor_bit(a) | floor_bit(b));
        expect_equal("elevator_floor_selector", elevator_floor_selector, b);
        // Arrival at the newest request
        stop_at(b);
        #1;
        expect_equal("activate_elevator", activate_elevator, 0);
        next_edge();
        expect_equal("panel_button_lights", panel_button_lights, '0);
        expect_equal("call_button_lights", call_button_lights, floor_bit(a));
        expect_equal("elevator_floor_selector", elevator_floor_selector, a);
        // Leave and call it again, it goes back on top
        stop_at(f);
        press(1'b1, b);
        expect_equal("elevator_floor_selector", elevator_floor_selector, b);
    endtask

    task automatic moving_state();
        floor_t f;
        floor_t g;
        f = floor_t'($urandom % FLOOR_COUNT);
        g = other_floor(f);
        drop_requests();
        current_floor_state = f;
        elevator_state      = MOVING_STATE;
        door_open_btn       = 1'b1;
        door_close_btn      = 1'b1;
        press(1'b1, g);
        expect_equal("panel_button_lights", panel_button_lights, floor_bit(g));
        expect_equal("activate_elevator", activate_elevator, 0);
        expect_equal("door_open_allowed", door_open_allowed, 0);
        expect_equal("door_close_allowed", door_close_allowed, 0);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
    endtask

    task automatic clearing();
        floor_t f;
        floor_t g;
        f = floor_t'(1 + $urandom % (FLOOR_COUNT - 1));
        g = floor_t'($urandom % f);
        drop_requests();
        stop_at(f);
        // Downward trip leaves the direction register low
        press(1'b1, g);
        press(1'b0, g);
        expect_equal("direction_selector", direction_selector, 0);
        emergency_btn = 1'b1;
        #1;
        expect_equal("elevator_floor_selector", elevator_floor_selector, EMERGENCY_FLOOR);
        expect_equal("activate_elevator", activate_elevator, 0);
        expect_equal("direction_selector", direction_selector, 1);
        next_edge();
        expect_equal("call_button_lights", call_button_lights, '0);
        expect_equal("panel_button_lights", panel_button_lights, '0);
        emergency_btn = 1'b0;
        #1;
        expect_equal("direction_selector", direction_selector, 1);
        expect_equal("elevator_floor_selector", elevator_floor_selector, f);
        // Power-off
        next_edge();
        press(1'b1, g);
        power_switch = 1'b0;
        next_edge();
        expect_equal("panel_button_lights", panel_button_lights, '0);
        expect_equal("call_button_lights", call_button_lights, '0);
        power_switch = 1'b1;
        #1;
        expect_equal("elevator_floor_selector", elevator_floor_selector, f);
        expect_equal("activate_elevator", activate_elevator, 0);
    endtask

    task automatic door_gating();
        floor_t f;
        f = floor_t'($urandom % FLOOR_COUNT);
        next_edge();
        stop_at(f);
        for (int i = 0; i < 4; i++) begin
            door_open_btn  = i[0];
            door_close_btn = i[1];
            #1;
            expect_equal("door_open_allowed", door_open_allowed, i[0]);
            expect_equal("door_close_allowed", door_close_allowed, i[1]);
            next_edge();
        end
        power_switch = 1'b0;
        #1;
        expect_equal("door_open_allowed", door_open_allowed, 0);
        expect_equal("door_close_allowed", door_close_allowed, 0);
        next_edge();
        power_switch   = 1'b1;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
    endtask

    ////////////////////
    // Run control
    ////////////////////

    initial begin
        void'($urandom(32'h96f3292b));
        clock               = 1'b0;
        reset_n             = 1'b0;
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = 4'h3;
        elevator_state      = 6'h03;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        next_edge();
        after_reset();
        accept_requests();
        most_recent_first();
        moving_state();
        clearing();
        door_gating();
        end_run();
    end

    // Watchdog well above the length of all tests
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
        error_count++;
        end_run();
    end

endmodule

`default_nettype wire
